// File: ddr2_front.f
+incdir+common
common/ddr2_cmd_pkg.sv
common/ddr2_geom_pkg.sv
ddr2_init/ddr2_initializer.sv
verilog/ddr2_refresh_timer.sv
verilog/ddr2_cmd_sequencer.sv
verilog/ddr2_front.sv
testbench/ddr2_front_tb.sv

// File: Bender.yml
package:
  name: ddr2_front

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ddr2_cmd_pkg.sv
      - common/ddr2_geom_pkg.sv
      - ddr2_init/ddr2_initializer.sv
      - verilog/ddr2_refresh_timer.sv
      - verilog/ddr2_cmd_sequencer.sv
      - verilog/ddr2_front.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/ddr2_front_tb.sv

// File: testbench/ddr2_front_tb.sv
`include "ddr2_defines.svh"

module ddr2_front_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import ddr2_cmd_pkg::*;
	import ddr2_geom_pkg::*;

	typedef struct packed {
		ddr2_cmd_t  cmd;
		ddr2_addr_t addr;
		ddr2_bank_t bank;
	} pin_cmd_t;

	typedef struct packed {
		int       cyc;
		logic     done; // init_done when the command was on the pins
		pin_cmd_t pins;
	} pin_evt_t;

	typedef struct packed {
		logic       write;
		ddr2_bank_t bank;
		ddr2_row_t  row;
		ddr2_col_t  col;
	} user_req_t;

	localparam int CYCLE_LIMIT = `DDR2_CKE_DELAY + 12 * `DDR2_CMD_GAP + `DDR2_SETTLE
		+ 40 * `DDR2_TRC + 3 * `DDR2_REFI;

	logic       CLK_n = 1'b0;
	logic       RST;
	logic       req;
	logic       req_write;
	ddr2_bank_t req_bank;
	ddr2_row_t  req_row;
	ddr2_col_t  req_col;
	logic       busy;
	logic       init_done;
	logic       cke;
	ddr2_cmd_t  cmd_pin;
	ddr2_addr_t addr_pin;
	ddr2_bank_t bank_pin;

	int        seed;
	int        cyc = 0;
	int        rst_rel_cyc;
	int        actv_cyc;
	int        done_cyc;
	int        n_cmds = 0;
	int        last_ref;
	int        ref_seen = 0;
	int        checked = 0;
	bit        cke_seen = 0;
	bit        done_seen = 0;
	bit        actv_seen = 0;
	bit        stop = 0;
	bit        stim_idle = 0;
	pin_evt_t  mon_q[$];
	user_req_t exp_q[$];

	always #2 CLK_n = ~CLK_n; // 4 ns period

	ddr2_front u_ddr2_front (
		.CLK_n     (CLK_n),
		.RST       (RST),
		.req       (req),
		.req_write (req_write),
		.req_bank  (req_bank),
		.req_row   (req_row),
		.req_col   (req_col),
		.busy      (busy),
		.init_done (init_done),
		.cke       (cke),
		.cmd_pin   (cmd_pin),
		.addr_pin  (addr_pin),
		.bank_pin  (bank_pin)
	);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s = %0h, expected %0h", $time, name, actual,
				expected);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	// pin values a correct front end produces, step 0..10 init, 11 ACTV, 12 READ/WRTE
	function automatic pin_cmd_t expected_cmd(input int step, input user_req_t r);
		pin_cmd_t e;
		e = {CMD_NOOP, 14'h000, 3'h0};
		case (step)
		0: e = {CMD_PRCH, 14'h400, 3'h1}; // precharge all
		1: e = {CMD_MRST, 14'h000, 3'h2}; // emr2
		2: e = {CMD_MRST, 14'h000, 3'h3}; // emr3
		3: e = {CMD_MRST, 14'h780, 3'h1};
		4: e = {CMD_MRST, 14'h532, 3'h0}; // dll reset
		5: e = {CMD_PRCH, 14'h400, 3'h0};
		6: e = {CMD_ARSR, 14'h000, 3'h0};
		7: e = {CMD_ARSR, 14'h000, 3'h0};
		8: e = {CMD_MRST, 14'h432, 3'h0};
		9: e = {CMD_MRST, 14'h780, 3'h1};
		10: e = {CMD_MRST, 14'h400, 3'h1};
		11: e = {CMD_ACTV, r.row, r.bank};
		12: e = {r.write ? CMD_WRTE : CMD_READ, {3'b000, 1'b1, r.col}, r.bank};
		default: e = {CMD_NOOP, 14'h000, 3'h0};
		endcase
		return e;
	endfunction

	always @(posedge CLK_n) begin
		cyc <= cyc + 1;
		if (cyc >= CYCLE_LIMIT)
			report_failure("timeout: sequence did not finish");
	end

	// pin monitor, samples mid cycle
	always @(negedge CLK_n) begin
		if (RST) begin
			if (!cke && cmd_pin !== CMD_NOOP)
				report_failure("a command was issued while cke was low");
			if (cke && !cke_seen) begin
				cke_seen = 1;
				check_val("cke rise cycle", cyc - rst_rel_cyc, `DDR2_CKE_DELAY);
			end
			if (init_done && !done_seen) begin
				done_seen = 1;
				done_cyc  = cyc;
				check_val("commands before init_done", n_cmds, 11);
			end
			if (cmd_pin !== CMD_NOOP) begin
				mon_q.push_back({cyc, init_done, cmd_pin, addr_pin, bank_pin});
				n_cmds++;
				if (cmd_pin === CMD_ACTV) begin
					actv_seen = 1;
					actv_cyc  = cyc;
				end
			end
			if (actv_seen && cyc - actv_cyc < `DDR2_TRC && !busy)
				report_failure("busy dropped before tRC had passed since ACTV");
		end
	end

	task automatic next_event(output pin_evt_t ev);
		while (mon_q.size() == 0)
			@(posedge CLK_n);
		ev = mon_q.pop_front();
	endtask

	task automatic check_init(input int idx, inout int last_cyc);
		pin_evt_t  ev;
		pin_cmd_t  exp_pins;
		user_req_t none;
		none = '0;
		next_event(ev);
		exp_pins = expected_cmd(idx, none);
		check_val("cmd_pin", ev.pins.cmd, exp_pins.cmd);
		if (exp_pins.cmd != CMD_ARSR) begin // refresh address is don't care
			check_val("addr_pin", ev.pins.addr, exp_pins.addr);
			check_val("bank_pin", ev.pins.bank, exp_pins.bank);
		end
		check_val("init_done", ev.done, 1'b0);
		if (idx > 0 && ev.cyc - last_cyc < `DDR2_CMD_GAP)
			report_failure("two init commands were closer than the command gap");
		last_cyc = ev.cyc;
	endtask

	task automatic check_next_event();
		pin_evt_t  ev;
		pin_evt_t  rw;
		pin_cmd_t  exp_pins;
		user_req_t r;
		next_event(ev);
		if (ev.pins.cmd == CMD_ARSR) begin
			if (ev.cyc - last_ref > `DDR2_REFI + `DDR2_TRC + 1)
				report_failure("no auto refresh within the refresh interval");
			last_ref = ev.cyc;
			ref_seen++;
		end else begin
			if (exp_q.size() == 0)
				report_failure("a command appeared without an accepted request");
			r = exp_q.pop_front();
			exp_pins = expected_cmd(11, r);
			check_val("cmd_pin", ev.pins.cmd, exp_pins.cmd);
			check_val("addr_pin", ev.pins.addr, exp_pins.addr);
			check_val("bank_pin", ev.pins.bank, exp_pins.bank);
			if (ref_seen > 0 && ev.cyc - last_ref < `DDR2_TRFC)
				report_failure("ACTV came before tRFC had passed since ARSR");
			next_event(rw);
			exp_pins = expected_cmd(12, r);
			check_val("cmd_pin", rw.pins.cmd, exp_pins.cmd);
			check_val("addr_pin", rw.pins.addr, exp_pins.addr);
			check_val("bank_pin", rw.pins.bank, exp_pins.bank);
			check_val("ACTV to READ/WRTE cycles", rw.cyc - ev.cyc, `DDR2_TRCD);
			checked++;
		end
	endtask

	task automatic drive_request();
		user_req_t r;
		r.write   = 1'($random(seed));
		r.bank    = 3'($random(seed));
		r.row     = 14'($random(seed));
		r.col     = 10'($random(seed));
		req_write = r.write;
		req_bank  = r.bank;
		req_row   = r.row;
		req_col   = r.col;
		if (!busy) begin
			req = 1'b1;
			exp_q.push_back(r);
		end else begin
			req = (($random(seed) & 3) == 0); // strobe into a busy DUT, must be dropped
		end
	endtask

	initial begin : stimulus
		seed      = 64;
		RST       = 1'b0;
		req       = 1'b0;
		req_write = 1'b0;
		req_bank  = '0;
		req_row   = '0;
		req_col   = '0;
		repeat (2) @(posedge CLK_n);
		#1;
		check_val("cke", cke, 1'b0);
		check_val("init_done", init_done, 1'b0);
		check_val("busy", busy, 1'b1);
		RST         = 1'b1;
		rst_rel_cyc = cyc;
		while (!init_done)
			@(posedge CLK_n);
		while (!stop) begin
			@(posedge CLK_n);
			#1;
			drive_request();
		end
		@(posedge CLK_n);
		#1;
		req       = 1'b0;
		stim_idle = 1;
	end

	initial begin : compare
		int last_cyc;
		last_cyc = 0;
		for (int i = 0; i < 11; i++)
			check_init(i, last_cyc);
		while (!done_seen)
			@(posedge CLK_n);
		last_ref = done_cyc + 1; // timer counts from the first edge with init_done high
		while (checked < 20 || ref_seen < 2)
			check_next_event();
		stop = 1;
		while (!stim_idle)
			@(posedge CLK_n);
		while (exp_q.size() != 0)
			check_next_event();
		$display("No errors");
		$finish;
	end

endmodule

// File: verilog/ddr2_front.sv
module ddr2_front (
	input  logic                      CLK_n,
	input  logic                      RST,
	input  logic                      req,
	input  logic                      req_write,
	input  ddr2_geom_pkg::ddr2_bank_t req_bank,
	input  ddr2_geom_pkg::ddr2_row_t  req_row,
	input  ddr2_geom_pkg::ddr2_col_t  req_col,
	output logic                      busy,
	output logic                      init_done,
	output logic                      cke,
	output ddr2_cmd_pkg::ddr2_cmd_t   cmd_pin,
	output ddr2_geom_pkg::ddr2_addr_t addr_pin,
	output ddr2_geom_pkg::ddr2_bank_t bank_pin
);
	import ddr2_cmd_pkg::*;
	import ddr2_geom_pkg::*;

	logic       refresh_due;
	ddr2_cmd_t  seq_cmd; // registered in the sequencer
	ddr2_addr_t seq_addr;
	ddr2_bank_t seq_bank;

	ddr2_refresh_timer u_refresh (
		.CLK_n       (CLK_n),
		.RST         (RST),
		.init_done   (init_done),
		.refresh_due (refresh_due)
	);

	ddr2_cmd_sequencer u_seq (
		.CLK_n       (CLK_n),
		.RST         (RST),
		.init_done   (init_done),
		.refresh_due (refresh_due),
		.req         (req),
		.req_write   (req_write),
		.req_bank    (req_bank),
		.req_row     (req_row),
		.req_col     (req_col),
		.busy        (busy),
		.seq_cmd     (seq_cmd),
		.seq_addr    (seq_addr),
		.seq_bank    (seq_bank)
	);

	// last stage, owns the pins
	ddr2_initializer u_init (
		.CLK_n     (CLK_n),
		.RST       (RST),
		.cke       (cke),
		.cmd_pin   (cmd_pin),
		.addr_pin  (addr_pin),
		.bank_pin  (bank_pin),
		.seq_cmd   (seq_cmd),
		.seq_addr  (seq_addr),
		.seq_bank  (seq_bank),
		.init_done (init_done)
	);

endmodule

// File: verilog/ddr2_cmd_sequencer.sv
`include "ddr2_defines.svh"

module ddr2_cmd_sequencer (
	input  logic                      CLK_n,
	input  logic                      RST,
	input  logic                      init_done,
	input  logic                      refresh_due,
	input  logic                      req,
	input  logic                      req_write,
	input  ddr2_geom_pkg::ddr2_bank_t req_bank,
	input  ddr2_geom_pkg::ddr2_row_t  req_row,
	input  ddr2_geom_pkg::ddr2_col_t  req_col,
	output logic                      busy,
	output ddr2_cmd_pkg::ddr2_cmd_t   seq_cmd,
	output ddr2_geom_pkg::ddr2_addr_t seq_addr,
	output ddr2_geom_pkg::ddr2_bank_t seq_bank
);
	import ddr2_cmd_pkg::*;
	import ddr2_geom_pkg::*;

	localparam int WAIT_MAX = (`DDR2_TRC > `DDR2_TRFC) ? `DDR2_TRC : `DDR2_TRFC;
	localparam int WAIT_W   = $clog2(WAIT_MAX + 1);

	seq_state_t        state;
	logic [WAIT_W-1:0] wait_cnt; // cycles since the last issued command
	logic              ref_pending;
	logic              ref_req;
	logic              accept;
	logic              wr_q;
	ddr2_bank_t        bank_q;
	ddr2_row_t         row_q;
	ddr2_col_t         col_q;

	assign ref_req = refresh_due | ref_pending;
	assign busy    = !init_done || state != idle || ref_req; // refresh wins over a request
	assign accept  = req && !busy;

	always_ff @(posedge CLK_n) begin
		if (accept) begin
			wr_q   <= req_write;
			bank_q <= req_bank;
			row_q  <= req_row;
			col_q  <= req_col;
		end
	end

	always_ff @(posedge CLK_n) begin
		if (!RST) begin
			state       <= idle;
			wait_cnt    <= '0;
			ref_pending <= 1'b0;
			seq_cmd     <= CMD_NOOP;
		end else begin
			seq_cmd  <= CMD_NOOP;
			wait_cnt <= wait_cnt + 1'b1;
			if (refresh_due && state != idle)
				ref_pending <= 1'b1; // hold it until idle
			case (state)
			idle: begin
				if (init_done && ref_req) begin
					seq_cmd     <= CMD_ARSR;
					ref_pending <= 1'b0;
					wait_cnt    <= WAIT_W'(1);
					state       <= ref_wait;
				end else if (accept) begin
					wait_cnt <= '0;
					state    <= act_wait;
				end
			end
			act_wait: begin
				if (wait_cnt == '0) begin
					seq_cmd  <= CMD_ACTV;
					seq_addr <= row_q;
					seq_bank <= bank_q;
				end else if (wait_cnt == WAIT_W'(`DDR2_TRCD)) begin
					seq_cmd  <= wr_q ? CMD_WRTE : CMD_READ;
					seq_addr <= {3'b000, 1'b1, col_q}; // a10 set for auto-precharge
					seq_bank <= bank_q;
					state    <= rw_wait;
				end
			end
			rw_wait: begin
				if (wait_cnt == WAIT_W'(`DDR2_TRC))
					state <= idle; // counted from the ACTV edge
			end
			ref_wait: begin
				if (wait_cnt == WAIT_W'(`DDR2_TRFC))
					state <= idle;
			end
			default: state <= idle;
			endcase
		end
	end

	// pins are still owned by the init ROM here
	assert property (@(posedge CLK_n) disable iff (!RST) !init_done |-> seq_cmd == CMD_NOOP);

endmodule

// File: verilog/ddr2_refresh_timer.sv
`include "ddr2_defines.svh"

module ddr2_refresh_timer (
	input  logic CLK_n,
	input  logic RST,
	input  logic init_done,
	output logic refresh_due
);
	localparam int REFI_W = $clog2(`DDR2_REFI);

	logic [REFI_W-1:0] interval_cnt;

	always_ff @(posedge CLK_n) begin
		if (!RST) begin
			interval_cnt <= '0;
			refresh_due  <= 1'b0;
		end else if (!init_done) begin
			interval_cnt <= '0; // no refreshes during power-up
			refresh_due  <= 1'b0;
		end else if (interval_cnt == REFI_W'(`DDR2_REFI - 1)) begin
			interval_cnt <= '0;
			refresh_due  <= 1'b1;
		end else begin
			interval_cnt <= interval_cnt + 1'b1;
			refresh_due  <= 1'b0;
		end
	end

	// sequencer counts pulses, a stretched one would be served twice
	assert property (@(posedge CLK_n) disable iff (!RST) refresh_due |=> !refresh_due);

endmodule

// File: ddr2_init/ddr2_initializer.sv
`include "ddr2_defines.svh"

module ddr2_initializer (
	input  logic                      CLK_n,
	input  logic                      RST,
	output logic                      cke,
	output ddr2_cmd_pkg::ddr2_cmd_t   cmd_pin,
	output ddr2_geom_pkg::ddr2_addr_t addr_pin,
	output ddr2_geom_pkg::ddr2_bank_t bank_pin,
	input  ddr2_cmd_pkg::ddr2_cmd_t   seq_cmd,
	input  ddr2_geom_pkg::ddr2_addr_t seq_addr,
	input  ddr2_geom_pkg::ddr2_bank_t seq_bank,
	output logic                      init_done
);
	import ddr2_cmd_pkg::*;
	import ddr2_geom_pkg::*;

	localparam int DELAY_W  = $clog2(`DDR2_CKE_DELAY);
	localparam int GAP_W    = $clog2(`DDR2_CMD_GAP);
	localparam int SETTLE_W = $clog2(`DDR2_SETTLE);
	localparam int ROM_LEN  = 11;

	logic [DELAY_W-1:0]  delay_cnt;
	logic [GAP_W-1:0]    gap_cnt;
	logic [SETTLE_W-1:0] settle_cnt;
	logic [3:0]          stage_cnt; // next rom entry, ROM_LEN when done

	ddr2_cmd_t  rom_cmd;
	ddr2_addr_t rom_addr;
	ddr2_bank_t rom_bank;

	ddr2_cmd_t  ini_cmd;
	ddr2_addr_t ini_addr;
	ddr2_bank_t ini_bank;

	// sequencer takes over the pins once init is done
	assign cmd_pin  = init_done ? seq_cmd : ini_cmd;
	assign addr_pin = init_done ? seq_addr : ini_addr;
	assign bank_pin = init_done ? seq_bank : ini_bank;

	// jedec power-up list
	always_comb begin
		rom_cmd  = CMD_MRST;
		rom_addr = 14'h400;
		rom_bank = 3'h0;
		case (stage_cnt)
		4'h0: begin
			rom_cmd  = CMD_PRCH; // precharge all
			rom_bank = 3'h1;
		end
		4'h1: begin
			rom_addr = 14'h000; // emr2
			rom_bank = 3'h2;
		end
		4'h2: begin
			rom_addr = 14'h000; // emr3
			rom_bank = 3'h3;
		end
		4'h3: begin
			rom_addr = 14'h780; // emr, ocd default
			rom_bank = 3'h1;
		end
		4'h4: rom_addr = 14'h532; // mr with dll reset
		4'h5: rom_cmd = CMD_PRCH;
		4'h6: rom_cmd = CMD_ARSR;
		4'h7: rom_cmd = CMD_ARSR;
		4'h8: rom_addr = 14'h432; // mr, dll reset cleared
		4'h9: begin
			rom_addr = 14'h780; // emr, ocd default
			rom_bank = 3'h1;
		end
		4'ha: rom_bank = 3'h1; // emr, ocd exit
		default: rom_cmd = CMD_NOOP;
		endcase
	end

	always_ff @(posedge CLK_n) begin
		if (!RST) begin
			cke        <= 1'b0;
			init_done  <= 1'b0;
			delay_cnt  <= '0;
			gap_cnt    <= '0;
			settle_cnt <= '0;
			stage_cnt  <= '0;
			ini_cmd    <= CMD_NOOP;
		end else begin
			ini_cmd <= CMD_NOOP; // only one cycle per command
			if (!cke) begin
				delay_cnt <= delay_cnt + 1'b1;
				if (delay_cnt == DELAY_W'(`DDR2_CKE_DELAY - 1))
					cke <= 1'b1;
			end else if (stage_cnt != 4'(ROM_LEN)) begin
				gap_cnt <= gap_cnt + 1'b1;
				if (gap_cnt == GAP_W'(`DDR2_CMD_GAP - 1)) begin
					ini_cmd   <= rom_cmd;
					ini_addr  <= rom_addr;
					ini_bank  <= rom_bank;
					stage_cnt <= stage_cnt + 1'b1;
					gap_cnt   <= '0;
				end
			end else if (!init_done) begin
				settle_cnt <= settle_cnt + 1'b1;
				if (settle_cnt == SETTLE_W'(`DDR2_SETTLE - 1))
					init_done <= 1'b1;
			end
		end
	end

	// nothing reaches the part before the clock is enabled
	assert property (@(posedge CLK_n) disable iff (!RST) !cke |-> cmd_pin == CMD_NOOP);

	// handover to the sequencer is one way
	assert property (@(posedge CLK_n) disable iff (!RST) init_done |=> init_done);

endmodule

// File: common/ddr2_geom_pkg.sv
package ddr2_geom_pkg;

	// bank select, three bits for an eight bank part
	typedef logic [2:0] ddr2_bank_t;

	// address pins a13..a0
	typedef logic [13:0] ddr2_addr_t;

	// row address, sent with ACTV
	typedef logic [13:0] ddr2_row_t;

	// column address, sent with READ/WRTE below a10
	typedef logic [9:0] ddr2_col_t;

endpackage

// File: common/ddr2_cmd_pkg.sv
package ddr2_cmd_pkg;

	// {ras_n, cas_n, we_n} as driven on the pins
	typedef logic [2:0] ddr2_cmd_t;

	localparam ddr2_cmd_t CMD_NOOP = 3'b111; // no operation
	localparam ddr2_cmd_t CMD_ACTV = 3'b011; // open a row
	localparam ddr2_cmd_t CMD_READ = 3'b101;
	localparam ddr2_cmd_t CMD_WRTE = 3'b100;
	localparam ddr2_cmd_t CMD_BTRM = 3'b110; // burst terminate
	localparam ddr2_cmd_t CMD_PRCH = 3'b010; // close row, a10 selects all banks
	localparam ddr2_cmd_t CMD_ARSR = 3'b001; // auto refresh
	localparam ddr2_cmd_t CMD_MRST = 3'b000; // mode register set, bank picks MR/EMRx

	// request sequencer states
	typedef enum logic [1:0] {
		idle,     // waiting for a request or a refresh
		act_wait, // ACTV issued, counting down tRCD
		rw_wait,  // READ/WRTE issued, counting out tRC
		ref_wait  // ARSR issued, counting out tRFC
	} seq_state_t;

endpackage

// File: common/ddr2_defines.svh
`ifndef DDR2_DEFINES_SVH
`define DDR2_DEFINES_SVH

// all values in controller clock cycles

// cke held low this long after reset
`define DDR2_CKE_DELAY 65536

// spacing of the init commands
`define DDR2_CMD_GAP 32

// noop time after the last init command
`define DDR2_SETTLE 256

`define DDR2_TRCD 4   // ACTV to READ/WRTE
`define DDR2_TRC 16   // ACTV to next command
`define DDR2_TRFC 32  // ARSR to next command

// average refresh interval
`define DDR2_REFI 1950

`endif
